//--- verilog.f
hdl/sysPkg.sv
hdl/northBridge.sv
hdl/dataMem.sv
hdl/southBridge.sv
hdl/timer.sv
hdl/microSystem.sv
verification/clockGen.sv
verification/microSystemTb.sv

//--- Makefile
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check $(LOG)"
	@echo "  clean  remove the build directory and $(LOG)"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal -f verilog.f \
		--top-module microSystemTb -Mdir obj_dir -o simv
	./obj_dir/simv | tee $(LOG)
	@if grep -q "Verification failed" $(LOG); then exit 1; fi
	@grep -q "Verification passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- verification/microSystemTb.sv
// Directed testbench that plays the CPU on the APB port and checks memory, bus errors and timers
module microSystemTb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int          timeoutCycles = 20;
    localparam logic [31:0] t0Base        = 32'h0000_7F00;
    localparam logic [31:0] t1Base        = 32'h0000_7F10;

    logic        clk;
    logic        reset;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [31:0] paddr;
    logic [31:0] pwdata;
    logic [3:0]  pstrb;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
    logic        interrupt;
    logic [5:0]  hwInt;

    integer      seed = 48;
    int          errors = 0;
    int          checks = 0;
    int          testsRun = 0;
    int          testStartErrors;
    int          lastWaits;
    logic [31:0] lastErr;
    logic [31:0] lastData;

    clockGen #(.periodNs(20), .resetCycles(5)) uClockGen (.clk(clk), .reset(reset));

    microSystem #(.dataWords(1024)) u_dut (
        .clk(clk), .reset(reset),
        .psel(psel), .penable(penable), .pwrite(pwrite),
        .paddr(paddr), .pwdata(pwdata), .pstrb(pstrb),
        .prdata(prdata), .pready(pready), .pslverr(pslverr),
        .interrupt(interrupt), .hwInt(hwInt)
    );

    task automatic checkEq(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error at %0t ns: %s = 0x%h, expected 0x%h", $time, name, got, exp);
        end
    endtask

    function automatic logic [31:0] mergeBytes(input logic [31:0] old, input logic [31:0] nw,
                                               input logic [3:0] strb);
        logic [31:0] res;
        res = old;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) res[8*b +: 8] = nw[8*b +: 8];
        end
        return res;
    endfunction

    // One APB transfer, setup then access until pready, sampled at the falling edge
    task automatic busCycle(input logic wr, input logic [31:0] addr, input logic [31:0] data,
                            input logic [3:0] strb);
        int waits;
        waits = 0;
        @(posedge clk);
        #1;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = data;
        pstrb   = strb;
        @(posedge clk);
        #1;
        penable = 1'b1;
        @(negedge clk);
        while (!pready && waits < timeoutCycles) begin
            waits++;
            @(negedge clk);
        end
        if (!pready) begin
            errors++;
            $display("Timeout: no pready within %0d cycles at address 0x%h", timeoutCycles, addr);
        end
        lastWaits = waits;
        lastErr   = 32'(pslverr);
        lastData  = prdata;
        @(posedge clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apbWrite(input logic [31:0] addr, input logic [31:0] data,
                            input logic [3:0] strb);
        busCycle(1'b1, addr, data, strb);
    endtask

    task automatic apbRead(input logic [31:0] addr);
        busCycle(1'b0, addr, 32'h0, 4'h0);
    endtask

    task automatic readCheck(input logic [31:0] addr, input logic [31:0] exp, input string name);
        apbRead(addr);
        checkEq(name, lastData, exp);
        checkEq({name, " pslverr"}, lastErr, 32'h0);
    endtask

    task automatic errorCheck(input string name);
        checkEq({name, " pslverr"}, lastErr, 32'h1);
        checkEq({name, " prdata"}, lastData, 32'h0);
        checkEq({name, " wait states"}, 32'(lastWaits), 32'h0);
    endtask

    task automatic finishTest(input string name);
        testsRun++;
        $display("%-22s done, %0d errors", name, errors - testStartErrors);
    endtask

    task automatic memByteWrites();
        logic [31:0] model [16];
        logic [31:0] data;
        logic [3:0]  strb;
        testStartErrors = errors;
        for (int i = 0; i < 16; i++) begin
            model[i] = $random(seed);
            apbWrite(32'h100 + 32'(i * 36), model[i], 4'hF);
            checkEq("write wait states", 32'(lastWaits), 32'h0);
        end
        // Single-byte overwrites walk across the lanes
        for (int i = 0; i < 16; i++) begin
            strb     = 4'b0001 << (i % 4);
            data     = $random(seed);
            model[i] = mergeBytes(model[i], data, strb);
            apbWrite(32'h100 + 32'(i * 36), data, strb);
        end
        for (int i = 0; i < 16; i++) begin
            readCheck(32'h100 + 32'(i * 36), model[i], "prdata");
            checkEq("read wait states", 32'(lastWaits), 32'h1);
        end
        finishTest("memByteWrites");
    endtask

    task automatic busErrors();
        logic [31:0] word0;
        testStartErrors = errors;
        word0 = $random(seed);
        apbWrite(32'h0, word0, 4'hF);
        // Would alias word 0 if it reached the RAM
        apbWrite(32'h0000_2000, ~word0, 4'hF);
        errorCheck("unmapped write");
        apbRead(32'h0000_2000);
        errorCheck("unmapped read");
        apbRead(t0Base + 32'h5);
        errorCheck("misaligned timer read");
        apbWrite(t0Base + 32'h6, 32'hDEAD_BEEF, 4'hF);
        errorCheck("misaligned timer write");
        apbWrite(t0Base + 32'h4, 32'hCAFE_F00D, 4'b0011);
        errorCheck("partial strobe timer write");
        readCheck(32'h0, word0, "memory word 0");
        readCheck(t0Base + 32'h4, 32'h0, "timer0 preset");
        finishTest("busErrors");
    endtask

    task automatic timerRegisters();
        testStartErrors = errors;
        apbWrite(t0Base + 32'h4, 32'h0000_1234, 4'hF);
        // Auto-reload with mask, enable left clear
        apbWrite(t0Base, 32'h0000_000A, 4'hF);
        readCheck(t0Base + 32'h4, 32'h0000_1234, "timer0 preset");
        readCheck(t0Base + 32'h8, 32'h0000_1234, "timer0 count");
        readCheck(t0Base, 32'h0000_000A, "timer0 control");
        apbWrite(t0Base + 32'h8, 32'h0000_0055, 4'hF);
        checkEq("count write pslverr", lastErr, 32'h0);
        readCheck(t0Base + 32'h8, 32'h0000_1234, "timer0 count after write");
        finishTest("timerRegisters");
    endtask

    task automatic oneShotInterrupt();
        int cycles;
        testStartErrors = errors;
        apbWrite(t0Base + 32'h4, 32'd10, 4'hF);
        apbWrite(t0Base, 32'h0000_0009, 4'hF);
        cycles = 0;
        @(negedge clk);
        while (!hwInt[0] && cycles < 50) begin
            checkEq("hwInt[1]", 32'(hwInt[1]), 32'h0);
            cycles++;
            @(negedge clk);
        end
        if (!hwInt[0]) begin
            errors++;
            $display("Timer 0 interrupt did not rise within 50 cycles");
        end
        // Expiry clears enable and leaves the mask
        readCheck(t0Base, 32'h0000_0008, "timer0 control after expiry");
        readCheck(t0Base + 32'h8, 32'h0, "timer0 count after expiry");
        @(negedge clk);
        checkEq("hwInt[0] before clear", 32'(hwInt[0]), 32'h1);
        apbWrite(t0Base, 32'h0, 4'hF);
        @(negedge clk);
        checkEq("hwInt[0] after clear", 32'(hwInt[0]), 32'h0);
        finishTest("oneShotInterrupt");
    endtask

    task automatic autoReloadInterrupt();
        int pulses;
        int runLen;
        testStartErrors = errors;
        apbWrite(t1Base + 32'h4, 32'd5, 4'hF);
        apbWrite(t1Base, 32'h0000_000B, 4'hF);
        pulses = 0;
        runLen = 0;
        for (int c = 0; c < 40; c++) begin
            @(negedge clk);
            checkEq("hwInt[5:3]", 32'(hwInt[5:3]), 32'h0);
            if (hwInt[1]) begin
                runLen++;
                if (runLen == 1) pulses++;
                if (runLen == 2) begin
                    errors++;
                    $display("Timer 1 interrupt held longer than one cycle at %0t ns", $time);
                end
            end else begin
                runLen = 0;
            end
        end
        checks++;
        if (pulses < 2) begin
            errors++;
            $display("Only %0d timer 1 interrupt pulses seen in 40 cycles", pulses);
        end
        apbWrite(t1Base, 32'h0, 4'hF);
        finishTest("autoReloadInterrupt");
    endtask

    task automatic externalInterrupt();
        logic [31:0] rnd;
        logic        level;
        testStartErrors = errors;
        for (int i = 0; i < 12; i++) begin
            @(posedge clk);
            #1;
            rnd       = $random(seed);
            level     = rnd[0];
            interrupt = level;
            #1;
            checkEq("hwInt[2]", 32'(hwInt[2]), 32'(level));
            checkEq("hwInt[5:3]", 32'(hwInt[5:3]), 32'h0);
        end
        interrupt = 1'b0;
        finishTest("externalInterrupt");
    endtask

    initial begin
        int resetWait;
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        paddr     = '0;
        pwdata    = '0;
        pstrb     = '0;
        interrupt = 1'b0;
        resetWait = 0;
        while (reset !== 1'b0 && resetWait < 20) begin
            resetWait++;
            @(posedge clk);
        end
        if (reset !== 1'b0) begin
            errors++;
            $display("Reset was never released");
        end
        memByteWrites();
        busErrors();
        timerRegisters();
        oneShotInterrupt();
        autoReloadInterrupt();
        externalInterrupt();
        $display("Tests run: %0d, checks: %0d, errors: %0d", testsRun, checks, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

//--- verification/clockGen.sv
// Testbench clock and synchronous reset source, instantiated once by the testbench top
module clockGen #(
    parameter int periodNs    = 20,
    parameter int resetCycles = 5
) (
    output logic clk,
    output logic reset
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
        forever #(periodNs / 2) clk = ~clk;
    end

    // Released just after the last reset edge
    initial begin
        reset = 1'b1;
        repeat (resetCycles) @(posedge clk);
        #1 reset = 1'b0;
    end

endmodule

//--- hdl/microSystem.sv
// Top level of the memory and peripheral side, exposing the CPU data bus as an APB completer
module microSystem #(
    parameter int dataWords = 1024
) (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            psel,
    input  logic                            penable,
    input  logic                            pwrite,
    input  logic [sysPkg::addrWidth-1:0]    paddr,
    input  logic [sysPkg::dataWidth-1:0]    pwdata,
    input  logic [sysPkg::strbWidth-1:0]    pstrb,
    output logic [sysPkg::dataWidth-1:0]    prdata,
    output logic                            pready,
    output logic                            pslverr,
    input  logic                            interrupt,
    output logic [sysPkg::hwIntWidth-1:0]   hwInt
);
    import sysPkg::*;

    // North bridge to data memory
    logic                  dmSel;
    logic                  dmWrite;
    logic [addrWidth-1:0]  dmAddr;
    logic [dataWidth-1:0]  dmWData;
    logic [strbWidth-1:0]  dmStrb;
    logic [dataWidth-1:0]  dmRData;

    // North bridge to south bridge
    logic                  sbSel;
    logic                  sbWrite;
    logic [addrWidth-1:0]  sbAddr;
    logic [dataWidth-1:0]  sbWData;
    logic [dataWidth-1:0]  sbRData;
    logic [hwIntWidth-1:0] sbHwInt;

    // South bridge to timers
    logic                     timer0Sel;
    logic [timerOffWidth-1:0] timer0Addr;
    logic [dataWidth-1:0]     timer0WData;
    logic [dataWidth-1:0]     timer0RData;
    logic                     timer0Irq;
    logic                     timer1Sel;
    logic [timerOffWidth-1:0] timer1Addr;
    logic [dataWidth-1:0]     timer1WData;
    logic [dataWidth-1:0]     timer1RData;
    logic                     timer1Irq;

    northBridge #(.dataWords(dataWords)) uNorthBridge (
        .clk(clk), .reset(reset),
        .psel(psel), .penable(penable), .pwrite(pwrite),
        .paddr(paddr), .pwdata(pwdata), .pstrb(pstrb),
        .prdata(prdata), .pready(pready), .pslverr(pslverr),
        .dmSel(dmSel), .dmWrite(dmWrite), .dmAddr(dmAddr),
        .dmWData(dmWData), .dmStrb(dmStrb), .dmRData(dmRData),
        .sbSel(sbSel), .sbWrite(sbWrite), .sbAddr(sbAddr), .sbWData(sbWData),
        .sbRData(sbRData), .sbHwInt(sbHwInt), .hwInt(hwInt)
    );

    dataMem #(.dataWords(dataWords)) uDataMem (
        .clk(clk), .reset(reset),
        .dmSel(dmSel), .dmWrite(dmWrite), .dmAddr(dmAddr),
        .dmWData(dmWData), .dmStrb(dmStrb), .dmRData(dmRData)
    );

    southBridge uSouthBridge (
        .sbSel(sbSel), .sbWrite(sbWrite), .sbAddr(sbAddr), .sbWData(sbWData),
        .interrupt(interrupt), .sbRData(sbRData), .sbHwInt(sbHwInt),
        .timer0Sel(timer0Sel), .timer0Addr(timer0Addr), .timer0WData(timer0WData),
        .timer0RData(timer0RData), .timer0Irq(timer0Irq),
        .timer1Sel(timer1Sel), .timer1Addr(timer1Addr), .timer1WData(timer1WData),
        .timer1RData(timer1RData), .timer1Irq(timer1Irq)
    );

    // Write enable is formed in each timer from its select and the bus write
    timer timer0 (
        .clk(clk), .reset(reset), .sel(timer0Sel), .write(sbWrite),
        .addr(timer0Addr), .wdata(timer0WData), .rdata(timer0RData), .irq(timer0Irq)
    );

    timer timer1 (
        .clk(clk), .reset(reset), .sel(timer1Sel), .write(sbWrite),
        .addr(timer1Addr), .wdata(timer1WData), .rdata(timer1RData), .irq(timer1Irq)
    );

endmodule

//--- hdl/timer.sv
// Programmable count-down timer with one-shot and auto-reload modes and a maskable interrupt
module timer (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                sel,
    input  logic                                write,
    input  logic [sysPkg::timerOffWidth-1:0]    addr,
    input  logic [sysPkg::dataWidth-1:0]        wdata,
    output logic [sysPkg::dataWidth-1:0]        rdata,
    output logic                                irq
);
    import sysPkg::*;

    logic [intMaskBit:0]  ctrl;
    logic [dataWidth-1:0] preset;
    logic [dataWidth-1:0] count;
    logic                 we;
    logic                 tick;
    logic                 expire;
    logic                 autoMode;
    timerMode             mode;

    assign we       = sel & write;
    assign mode     = timerMode'(ctrl[modeHiBit:modeLoBit]);
    assign autoMode = (mode == autoReload);

    // Count moves only while enabled and nonzero
    assign tick   = ctrl[enableBit] & (count != '0);
    assign expire = tick & (count == dataWidth'(1));

    always_ff @(posedge clk) begin
        if (reset) begin
            ctrl   <= '0;
            preset <= '0;
            count  <= '0;
            irq    <= 1'b0;
        end else begin
            // Auto-reload irq is a single-cycle pulse
            if (autoMode) begin
                irq <= 1'b0;
            end
            if (tick) begin
                if (expire) begin
                    if (autoMode) begin
                        count <= preset;
                    end else begin
                        count           <= '0;
                        ctrl[enableBit] <= 1'b0;
                    end
                    if (ctrl[intMaskBit]) begin
                        irq <= 1'b1;
                    end
                end else begin
                    count <= count - 1'b1;
                end
            end
            // Software writes override the counter in the same cycle
            if (we) begin
                case (addr)
                    ctrlOffset: begin
                        ctrl <= wdata[intMaskBit:0];
                        irq  <= 1'b0;
                    end
                    presetOffset: begin
                        preset <= wdata;
                        count  <= wdata;
                    end
                    // count is read-only
                    default: ;
                endcase
            end
        end
    end

    always_comb begin
        case (addr)
            ctrlOffset:   rdata = dataWidth'(ctrl);
            presetOffset: rdata = preset;
            countOffset:  rdata = count;
            default:      rdata = '0;
        endcase
    end

    // Irq only stands while the mask is set
    assert property (@(posedge clk) disable iff (reset) irq |-> ctrl[intMaskBit]);

endmodule

//--- hdl/southBridge.sv
// Combinational south bridge that decodes the two timer windows and gathers hardware interrupts
module southBridge (
    input  logic                                sbSel,
    input  logic                                sbWrite,
    input  logic [sysPkg::addrWidth-1:0]        sbAddr,
    input  logic [sysPkg::dataWidth-1:0]        sbWData,
    input  logic                                interrupt,
    output logic [sysPkg::dataWidth-1:0]        sbRData,
    output logic [sysPkg::hwIntWidth-1:0]       sbHwInt,
    output logic                                timer0Sel,
    output logic [sysPkg::timerOffWidth-1:0]    timer0Addr,
    output logic [sysPkg::dataWidth-1:0]        timer0WData,
    input  logic [sysPkg::dataWidth-1:0]        timer0RData,
    input  logic                                timer0Irq,
    output logic                                timer1Sel,
    output logic [sysPkg::timerOffWidth-1:0]    timer1Addr,
    output logic [sysPkg::dataWidth-1:0]        timer1WData,
    input  logic [sysPkg::dataWidth-1:0]        timer1RData,
    input  logic                                timer1Irq
);
    import sysPkg::*;

    logic t0Hit;
    logic t1Hit;

    assign t0Hit = (sbAddr - timer0Base) < addrWidth'(timerSpan);
    assign t1Hit = (sbAddr - timer1Base) < addrWidth'(timerSpan);

    // Each timer gets its own select and window offset
    assign timer0Sel   = sbSel & t0Hit;
    assign timer0Addr  = timerOffWidth'(sbAddr - timer0Base);
    assign timer0WData = sbWData;

    assign timer1Sel   = sbSel & t1Hit;
    assign timer1Addr  = timerOffWidth'(sbAddr - timer1Base);
    assign timer1WData = sbWData;

    // Read data only for a selected read
    always_comb begin
        sbRData = '0;
        if (sbSel && !sbWrite) begin
            if (t0Hit) begin
                sbRData = timer0RData;
            end else if (t1Hit) begin
                sbRData = timer1RData;
            end
        end
    end

    // Interrupt vector, upper lines unused
    always_comb begin
        sbHwInt    = '0;
        sbHwInt[0] = timer0Irq;
        sbHwInt[1] = timer1Irq;
        sbHwInt[2] = interrupt;
    end

endmodule

//--- hdl/dataMem.sv
// Word-organized data RAM with byte-lane writes and a registered read port
module dataMem #(
    parameter int dataWords = 1024
) (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            dmSel,
    input  logic                            dmWrite,
    input  logic [sysPkg::addrWidth-1:0]    dmAddr,
    input  logic [sysPkg::dataWidth-1:0]    dmWData,
    input  logic [sysPkg::strbWidth-1:0]    dmStrb,
    output logic [sysPkg::dataWidth-1:0]    dmRData
);
    import sysPkg::*;

    localparam int idxWidth = $clog2(dataWords);

    logic [dataWidth-1:0] mem [dataWords];
    logic [idxWidth-1:0]  idx;

    // Byte address to word index
    assign idx = dmAddr[idxWidth+1:2];

    always_ff @(posedge clk) begin
        if (dmSel && dmWrite) begin
            for (int i = 0; i < strbWidth; i++) begin
                if (dmStrb[i]) begin
                    mem[idx][8*i +: 8] <= dmWData[8*i +: 8];
                end
            end
        end
    end

    // Read register, loaded on every selected read
    always_ff @(posedge clk) begin
        if (reset) begin
            dmRData <= '0;
        end else if (dmSel && !dmWrite) begin
            dmRData <= mem[idx];
        end
    end

    // Bridge decode must keep the index inside the array
    assert property (@(posedge clk) disable iff (reset)
        dmSel |-> (dmAddr[addrWidth-1:2] < (addrWidth-2)'(dataWords)));

endmodule

//--- hdl/northBridge.sv
// APB completer that decodes the CPU data bus and routes it to data memory or the south bridge
module northBridge #(
    parameter int dataWords = 1024
) (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            psel,
    input  logic                            penable,
    input  logic                            pwrite,
    input  logic [sysPkg::addrWidth-1:0]    paddr,
    input  logic [sysPkg::dataWidth-1:0]    pwdata,
    input  logic [sysPkg::strbWidth-1:0]    pstrb,
    output logic [sysPkg::dataWidth-1:0]    prdata,
    output logic                            pready,
    output logic                            pslverr,
    output logic                            dmSel,
    output logic                            dmWrite,
    output logic [sysPkg::addrWidth-1:0]    dmAddr,
    output logic [sysPkg::dataWidth-1:0]    dmWData,
    output logic [sysPkg::strbWidth-1:0]    dmStrb,
    input  logic [sysPkg::dataWidth-1:0]    dmRData,
    output logic                            sbSel,
    output logic                            sbWrite,
    output logic [sysPkg::addrWidth-1:0]    sbAddr,
    output logic [sysPkg::dataWidth-1:0]    sbWData,
    input  logic [sysPkg::dataWidth-1:0]    sbRData,
    input  logic [sysPkg::hwIntWidth-1:0]   sbHwInt,
    output logic [sysPkg::hwIntWidth-1:0]   hwInt
);
    import sysPkg::*;

    localparam logic [addrWidth-1:0] dmLimit = addrWidth'(dataWords * 4);

    logic access;
    logic dmHit;
    logic sbHit;
    logic timerErr;
    logic err;
    logic memRead;
    logic waitFlag;

    assign access = psel & penable;

    // Address decode, subtraction keeps each window test base-relative
    assign dmHit = (paddr - dmBase) < dmLimit;
    assign sbHit = ((paddr - timer0Base) < addrWidth'(timerSpan))
                 | ((paddr - timer1Base) < addrWidth'(timerSpan));

    // Timers only take aligned, full-word accesses
    assign timerErr = sbHit & ((paddr[1:0] != 2'b00) | (pwrite & (pstrb != '1)));
    assign err      = ~(dmHit | sbHit) | timerErr;
    assign memRead  = dmHit & ~pwrite;

    // Wait state for the registered memory read
    always_ff @(posedge clk) begin
        if (reset) begin
            waitFlag <= 1'b0;
        end else begin
            waitFlag <= access & memRead & ~waitFlag;
        end
    end

    assign pready  = access & (~memRead | waitFlag);
    assign pslverr = access & err;

    // Targets see only the access phase, so writes commit on the completing edge
    assign dmSel   = access & dmHit & ~waitFlag;
    assign dmWrite = pwrite;
    assign dmAddr  = paddr - dmBase;
    assign dmWData = pwdata;
    assign dmStrb  = pstrb;

    assign sbSel   = access & sbHit & ~timerErr;
    assign sbWrite = pwrite;
    assign sbAddr  = paddr;
    assign sbWData = pwdata;

    always_comb begin
        if (err) begin
            prdata = '0;
        end else if (dmHit) begin
            prdata = dmRData;
        end else begin
            prdata = sbRData;
        end
    end

    assign hwInt = sbHwInt;

    // Requester protocol checks
    assert property (@(posedge clk) disable iff (reset) penable |-> psel);
    assert property (@(posedge clk) disable iff (reset) waitFlag |-> $stable(paddr));

endmodule

//--- hdl/sysPkg.sv
// Shared bus widths, memory map and timer definitions, imported by every design module
package sysPkg;

    // Bus widths
    parameter int addrWidth  = 32;
    parameter int dataWidth  = 32;
    parameter int strbWidth  = 4;
    // Maps to MIPS interrupt lines 7..2
    parameter int hwIntWidth = 6;

    // Memory map
    parameter logic [addrWidth-1:0] dmBase     = 32'h0000_0000;
    parameter logic [addrWidth-1:0] timer0Base = 32'h0000_7F00;
    parameter logic [addrWidth-1:0] timer1Base = 32'h0000_7F10;
    parameter int                   timerSpan  = 16;

    // Byte offset inside one timer window
    parameter int timerOffWidth = $clog2(timerSpan);

    // Timer register offsets
    parameter logic [timerOffWidth-1:0] ctrlOffset   = 4'h0;
    parameter logic [timerOffWidth-1:0] presetOffset = 4'h4;
    parameter logic [timerOffWidth-1:0] countOffset  = 4'h8;

    // Control register layout
    parameter int enableBit  = 0;
    parameter int modeLoBit  = 1;
    parameter int modeHiBit  = 2;
    parameter int intMaskBit = 3;

    // Codes 2 and 3 fall back to one-shot behavior
    typedef enum logic [1:0] {
        oneShot    = 2'd0,
        autoReload = 2'd1
    } timerMode;

endpackage
